// ==== hw/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ============================================================
// Datapath widths
// ============================================================

// Data word and byte address
`define LSU_XLEN 32

// Physical register tag
`define LSU_TAG_W 6

// ROB index
`define LSU_ROB_W 6

// ============================================================
// Queue sizing
// ============================================================

// Default depths, any power of two from 2 up
`define LSU_LQ_DEPTH 8
`define LSU_SQ_DEPTH 8

`endif

// ==== hw/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

    // ============================================================
    // Vector types
    // ============================================================

    // Data word or byte address
    typedef logic [`LSU_XLEN-1:0] xlen_t;

    // Physical destination register tag
    typedef logic [`LSU_TAG_W-1:0] tag_t;

    // Reorder buffer index
    typedef logic [`LSU_ROB_W-1:0] rob_idx_t;

    // ============================================================
    // Load issuer states
    // ============================================================

    // LD_READ waits on a scratchpad read for the head load,
    // LD_DISCARD finishes a read cut off by a flush
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_READ,
        LD_DISCARD
    } load_state_t;

endpackage

// ==== hw/lsu_dispatch.sv ====
`timescale 1ns/1ps

module lsu_dispatch import lsu_pkg::*; (
    input  logic  alloc_en,
    input  logic  is_load,
    input  logic  flush,
    input  xlen_t base_addr,
    input  xlen_t offset,
    input  logic  lq_free,
    input  logic  sq_free,
    output logic  alloc_ready,
    output logic  lq_alloc,
    output logic  sq_alloc,
    output logic  misaligned,
    output xlen_t alloc_addr
);

    logic target_free;
    logic accept;

    // ============================================================
    // Address generation
    // ============================================================

    assign alloc_addr = base_addr + offset;

    // Word access needs the two low bits clear
    assign misaligned = (alloc_addr[1:0] != 2'b00);

    // ============================================================
    // Queue routing
    // ============================================================

    // Ready follows whichever queue this operation goes to
    assign target_free = is_load ? lq_free : sq_free;
    assign alloc_ready = target_free;

    // No new entries in a flush cycle
    assign accept = alloc_en && target_free && !flush;

    assign lq_alloc = accept && is_load;
    assign sq_alloc = accept && !is_load;

endmodule

// ==== hw/lsu_load_queue.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_load_queue import lsu_pkg::*; #(
    parameter int DEPTH = `LSU_LQ_DEPTH
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  lq_alloc,
    input  logic  misaligned,
    input  xlen_t alloc_addr,
    input  tag_t  phys_rd,
    input  logic  fwd_hit,
    input  xlen_t fwd_data,
    input  logic  ld_grant,
    input  xlen_t mem_rdata,
    input  logic  mem_error,
    output logic  lq_free,
    output xlen_t fwd_addr,
    output logic  ld_req,
    output xlen_t ld_addr,
    output logic  cdb_valid,
    output tag_t  cdb_tag,
    output xlen_t cdb_value,
    output logic  cdb_exception
);

    localparam int PTR_W = $clog2(DEPTH);

    // Entry payload
    xlen_t            addr_q [DEPTH];
    tag_t             tag_q  [DEPTH];
    logic [DEPTH-1:0] mis_q;

    // Extra pointer bit tells full from empty
    logic [PTR_W:0]   head;
    logic [PTR_W:0]   tail;
    logic [PTR_W-1:0] head_idx;
    logic [PTR_W-1:0] tail_idx;
    logic             empty;
    logic             full;

    load_state_t      state;
    xlen_t            rd_addr;
    logic             head_mis;
    logic             complete_fast;
    logic             complete_read;
    logic             start_read;

    assign head_idx = head[PTR_W-1:0];
    assign tail_idx = tail[PTR_W-1:0];
    assign empty    = (head == tail);
    assign full     = (head[PTR_W] != tail[PTR_W]) && (head_idx == tail_idx);
    assign lq_free  = !full;

    assign head_mis = mis_q[head_idx];
    assign fwd_addr = addr_q[head_idx];

    // ============================================================
    // Issue decisions for the head load
    // ============================================================

    // Misaligned or forwarded loads finish without the memory port
    assign complete_fast = (state == LD_IDLE) && !empty && (head_mis || fwd_hit);
    assign start_read    = (state == LD_IDLE) && !empty && !head_mis && !fwd_hit;
    assign complete_read = (state == LD_READ) && ld_grant;

    // Request held from a registered address, so a flush cannot move it
    assign ld_req  = (state == LD_READ) || (state == LD_DISCARD);
    assign ld_addr = rd_addr;

    // ============================================================
    // Control state
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= LD_IDLE;
            head      <= '0;
            tail      <= '0;
            cdb_valid <= 1'b0;
        end else if (flush) begin
            head      <= tail;
            cdb_valid <= 1'b0;
            // A read that owns the port must still run to completion
            if (state == LD_READ && !ld_grant) begin
                state <= LD_DISCARD;
            end else if (state == LD_READ) begin
                state <= LD_IDLE;
            end else if (state == LD_DISCARD && ld_grant) begin
                state <= LD_IDLE;
            end
        end else begin
            cdb_valid <= complete_fast || complete_read;
            if (lq_alloc) begin
                tail <= tail + 1'b1;
            end
            if (complete_fast || complete_read) begin
                head <= head + 1'b1;
            end
            case (state)
                LD_IDLE: begin
                    if (start_read) begin
                        state <= LD_READ;
                    end
                end
                LD_READ: begin
                    if (ld_grant) begin
                        state <= LD_IDLE;
                    end
                end
                LD_DISCARD: begin
                    // Data of the cut-off read is dropped
                    if (ld_grant) begin
                        state <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    // ============================================================
    // Payload and CDB data
    // ============================================================

    always_ff @(posedge clk) begin
        if (lq_alloc) begin
            addr_q[tail_idx] <= alloc_addr;
            tag_q[tail_idx]  <= phys_rd;
            mis_q[tail_idx]  <= misaligned;
        end
        if (start_read) begin
            rd_addr <= addr_q[head_idx];
        end
        if (complete_fast) begin
            cdb_tag       <= tag_q[head_idx];
            cdb_value     <= head_mis ? '0 : fwd_data;
            cdb_exception <= head_mis;
        end else if (complete_read) begin
            cdb_tag       <= tag_q[head_idx];
            cdb_value     <= mem_rdata;
            cdb_exception <= mem_error;
        end
    end

endmodule

// ==== hw/lsu_store_queue.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_store_queue import lsu_pkg::*; #(
    parameter int DEPTH = `LSU_SQ_DEPTH
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     sq_alloc,
    input  logic     misaligned,
    input  xlen_t    alloc_addr,
    input  xlen_t    store_data,
    input  rob_idx_t rob_idx,
    input  logic     commit_en,
    input  rob_idx_t commit_rob_idx,
    input  xlen_t    fwd_addr,
    input  logic     st_grant,
    output logic     sq_free,
    output logic     fwd_hit,
    output xlen_t    fwd_data,
    output logic     st_req,
    output xlen_t    st_addr,
    output xlen_t    st_wdata,
    output logic     store_exception
);

    localparam int PTR_W = $clog2(DEPTH);

    xlen_t            addr_q [DEPTH];
    xlen_t            data_q [DEPTH];
    rob_idx_t         rob_q  [DEPTH];
    logic [DEPTH-1:0] mis_q;
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] committed_q;

    logic [PTR_W:0]   head;
    logic [PTR_W:0]   tail;
    logic [PTR_W:0]   keep_cnt;
    logic [PTR_W-1:0] head_idx;
    logic [PTR_W-1:0] tail_idx;
    logic             full;
    logic             head_ready;
    logic             retire;

    assign head_idx = head[PTR_W-1:0];
    assign tail_idx = tail[PTR_W-1:0];
    assign full     = (head[PTR_W] != tail[PTR_W]) && (head_idx == tail_idx);
    assign sq_free  = !full;

    // ============================================================
    // In-order drain
    // ============================================================

    assign head_ready = valid_q[head_idx] && committed_q[head_idx];
    assign st_req     = head_ready && !mis_q[head_idx];
    assign st_addr    = addr_q[head_idx];
    assign st_wdata   = data_q[head_idx];

    // Misaligned head leaves at once without a write
    assign retire = head_ready && (mis_q[head_idx] || st_grant);

    // Committed entries form a run from the head; flush keeps that run
    always_comb begin
        logic             run;
        logic [PTR_W-1:0] idx;
        run      = 1'b1;
        keep_cnt = '0;
        for (int k = 0; k < DEPTH; k++) begin
            idx = head_idx + PTR_W'(k);
            if (run && valid_q[idx] && committed_q[idx]) begin
                keep_cnt = keep_cnt + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

    // ============================================================
    // Forwarding search, oldest first so the youngest match wins
    // ============================================================

    always_comb begin
        logic [PTR_W-1:0] idx;
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int k = 0; k < DEPTH; k++) begin
            idx = head_idx + PTR_W'(k);
            if (valid_q[idx] && committed_q[idx] && !mis_q[idx] &&
                addr_q[idx] == fwd_addr) begin
                fwd_hit  = 1'b1;
                fwd_data = data_q[idx];
            end
        end
    end

    // ============================================================
    // Control state
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q         <= '0;
            committed_q     <= '0;
            head            <= '0;
            tail            <= '0;
            store_exception <= 1'b0;
        end else begin
            store_exception <= head_ready && mis_q[head_idx];
            if (flush) begin
                // Uncommitted stores are dropped
                valid_q <= valid_q & committed_q;
                tail    <= head + keep_cnt;
            end else begin
                if (sq_alloc) begin
                    valid_q[tail_idx]     <= 1'b1;
                    committed_q[tail_idx] <= 1'b0;
                    tail                  <= tail + 1'b1;
                end
                if (commit_en) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        if (valid_q[i] && rob_q[i] == commit_rob_idx) begin
                            committed_q[i] <= 1'b1;
                        end
                    end
                end
            end
            if (retire) begin
                valid_q[head_idx]     <= 1'b0;
                committed_q[head_idx] <= 1'b0;
                head                  <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sq_alloc) begin
            addr_q[tail_idx] <= alloc_addr;
            data_q[tail_idx] <= store_data;
            rob_q[tail_idx]  <= rob_idx;
            mis_q[tail_idx]  <= misaligned;
        end
    end

endmodule

// ==== hw/lsu_mem_arbiter.sv ====
`timescale 1ns/1ps

module lsu_mem_arbiter import lsu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  st_req,
    input  xlen_t st_addr,
    input  xlen_t st_wdata,
    input  logic  ld_req,
    input  xlen_t ld_addr,
    input  logic  mem_ready,
    output logic  st_grant,
    output logic  ld_grant,
    output logic  mem_req,
    output logic  mem_we,
    output xlen_t mem_addr,
    output xlen_t mem_wdata
);

    // Port is locked to one owner while its transfer is open
    logic locked;
    logic owner_st;
    logic sel_st;
    logic done;

    // ============================================================
    // Owner select
    // ============================================================

    // Store drain first when the port is free
    assign sel_st = locked ? owner_st : st_req;

    assign mem_req   = sel_st ? st_req : ld_req;
    assign mem_we    = sel_st;
    assign mem_addr  = sel_st ? st_addr : ld_addr;
    assign mem_wdata = sel_st ? st_wdata : '0;

    assign done = mem_req && mem_ready;

    // Only the owner sees mem_ready
    assign st_grant = done && sel_st;
    assign ld_grant = done && !sel_st;

    // ============================================================
    // Lock register
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            locked   <= 1'b0;
            owner_st <= 1'b0;
        end else if (done) begin
            locked <= 1'b0;
        end else if (mem_req && !locked) begin
            locked   <= 1'b1;
            owner_st <= sel_st;
        end
    end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top import lsu_pkg::*; #(
    parameter int LQ_DEPTH = `LSU_LQ_DEPTH,
    parameter int SQ_DEPTH = `LSU_SQ_DEPTH
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    // Allocation from rename
    input  logic     alloc_en,
    input  logic     is_load,
    input  xlen_t    base_addr,
    input  xlen_t    offset,
    input  tag_t     phys_rd,
    input  rob_idx_t rob_idx,
    input  xlen_t    store_data,
    output logic     alloc_ready,
    // Store commit
    input  logic     commit_en,
    input  rob_idx_t commit_rob_idx,
    // Load results
    output logic     cdb_valid,
    output tag_t     cdb_tag,
    output xlen_t    cdb_value,
    output logic     cdb_exception,
    output logic     store_exception,
    // Scratchpad
    output logic     mem_req,
    output logic     mem_we,
    output xlen_t    mem_addr,
    output xlen_t    mem_wdata,
    input  logic     mem_ready,
    input  xlen_t    mem_rdata,
    input  logic     mem_error
);

    logic  lq_alloc, sq_alloc, misaligned, lq_free, sq_free;
    xlen_t alloc_addr;
    logic  fwd_hit;
    xlen_t fwd_addr, fwd_data;
    logic  st_req, st_grant, ld_req, ld_grant;
    xlen_t st_addr, st_wdata, ld_addr;

    lsu_dispatch i_lsu_dispatch (
        .alloc_en    (alloc_en),
        .is_load     (is_load),
        .flush       (flush),
        .base_addr   (base_addr),
        .offset      (offset),
        .lq_free     (lq_free),
        .sq_free     (sq_free),
        .alloc_ready (alloc_ready),
        .lq_alloc    (lq_alloc),
        .sq_alloc    (sq_alloc),
        .misaligned  (misaligned),
        .alloc_addr  (alloc_addr)
    );

    lsu_load_queue #(.DEPTH(LQ_DEPTH)) i_lsu_load_queue (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .lq_alloc      (lq_alloc),
        .misaligned    (misaligned),
        .alloc_addr    (alloc_addr),
        .phys_rd       (phys_rd),
        .fwd_hit       (fwd_hit),
        .fwd_data      (fwd_data),
        .ld_grant      (ld_grant),
        .mem_rdata     (mem_rdata),
        .mem_error     (mem_error),
        .lq_free       (lq_free),
        .fwd_addr      (fwd_addr),
        .ld_req        (ld_req),
        .ld_addr       (ld_addr),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .cdb_exception (cdb_exception)
    );

    lsu_store_queue #(.DEPTH(SQ_DEPTH)) i_lsu_store_queue (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .sq_alloc        (sq_alloc),
        .misaligned      (misaligned),
        .alloc_addr      (alloc_addr),
        .store_data      (store_data),
        .rob_idx         (rob_idx),
        .commit_en       (commit_en),
        .commit_rob_idx  (commit_rob_idx),
        .fwd_addr        (fwd_addr),
        .st_grant        (st_grant),
        .sq_free         (sq_free),
        .fwd_hit         (fwd_hit),
        .fwd_data        (fwd_data),
        .st_req          (st_req),
        .st_addr         (st_addr),
        .st_wdata        (st_wdata),
        .store_exception (store_exception)
    );

    lsu_mem_arbiter i_lsu_mem_arbiter (
        .clk       (clk),
        .reset     (reset),
        .st_req    (st_req),
        .st_addr   (st_addr),
        .st_wdata  (st_wdata),
        .ld_req    (ld_req),
        .ld_addr   (ld_addr),
        .mem_ready (mem_ready),
        .st_grant  (st_grant),
        .ld_grant  (ld_grant),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

// ==== tests/lsu_clock_gen.sv ====
`timescale 1ns/1ps

module lsu_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the active edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== tests/lsu_asserts.sv ====
`timescale 1ns/1ps

module lsu_asserts import lsu_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  flush,
    input logic  mem_req,
    input logic  mem_we,
    input logic  mem_ready,
    input xlen_t mem_addr,
    input xlen_t mem_wdata,
    input logic  cdb_valid
);

    int failures;

    initial failures = 0;

    // ============================================================
    // Scratchpad handshake
    // ============================================================

    // Request and its fields held until the scratchpad accepts
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ready |=> mem_req && $stable(mem_we) &&
            $stable(mem_addr) && $stable(mem_wdata))
    else begin
        $error("memory request dropped or changed before mem_ready");
        failures++;
    end

    // No request while in reset
    a_reset_idle: assert property (@(posedge clk) reset |-> !mem_req)
    else begin
        $error("mem_req high during reset");
        failures++;
    end

    // ============================================================
    // Flush
    // ============================================================

    a_flush_cdb: assert property (@(posedge clk) disable iff (reset)
        flush |=> !cdb_valid)
    else begin
        $error("cdb_valid high in the cycle after flush");
        failures++;
    end

endmodule

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int unsigned SEED = 32'h5633_b90e;
    localparam int ROUNDS     = 8;
    localparam int MAX_BATCH  = 6;
    // Allocations plus commits of the random rounds, with room for the directed tests
    localparam int OP_BOUND   = ROUNDS * 3 * MAX_BATCH + 60;
    localparam int WAIT_LIMIT = 2000;
    localparam xlen_t REGION  = 32'h0000_0100;
    localparam int WORDS      = `LSU_SQ_DEPTH;

    logic clk, reset;
    logic flush, alloc_en, is_load, alloc_ready, commit_en;
    xlen_t base_addr, offset, store_data;
    tag_t phys_rd, cdb_tag;
    rob_idx_t rob_idx, commit_rob_idx;
    logic cdb_valid, cdb_exception, store_exception;
    xlen_t cdb_value;
    logic mem_req, mem_we, mem_ready, mem_error;
    xlen_t mem_addr, mem_wdata, mem_rdata;

    // Scratchpad contents and committed values
    xlen_t scratch [xlen_t];
    xlen_t model [xlen_t];
    // Loads in flight, oldest first
    tag_t exp_tag [$];
    xlen_t exp_val [$];
    logic exp_exc [$];
    // Stores allocated but not yet committed
    xlen_t pend_addr [$];
    xlen_t pend_data [$];
    rob_idx_t pend_rob [$];

    int errors, loads_checked, exp_writes, got_writes;
    int stx_seen, stx_expected, watch_hits;
    xlen_t watch_addr;
    logic mem_stall, inject_error;
    tag_t next_tag;
    rob_idx_t next_rob;
    string test_name;

    lsu_clock_gen i_lsu_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    lsu_top i_lsu_top (
        .clk(clk), .reset(reset), .flush(flush),
        .alloc_en(alloc_en), .is_load(is_load), .base_addr(base_addr), .offset(offset),
        .phys_rd(phys_rd), .rob_idx(rob_idx), .store_data(store_data),
        .alloc_ready(alloc_ready),
        .commit_en(commit_en), .commit_rob_idx(commit_rob_idx),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .cdb_exception(cdb_exception), .store_exception(store_exception),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_error(mem_error)
    );

    bind lsu_top lsu_asserts i_lsu_asserts (
        .clk(clk), .reset(reset), .flush(flush), .mem_req(mem_req), .mem_we(mem_we),
        .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .cdb_valid(cdb_valid)
    );

    // ============================================================
    // Helpers
    // ============================================================

    // Unwritten words read back as their own address
    function automatic xlen_t word_value(xlen_t a);
        if (model.exists(a)) begin
            return model[a];
        end
        return a;
    endfunction

    function automatic xlen_t scratch_value(xlen_t a);
        if (scratch.exists(a)) begin
            return scratch[a];
        end
        return a;
    endfunction

    function automatic xlen_t random_word();
        return REGION + xlen_t'(4 * ($urandom % WORDS));
    endfunction

    task automatic compare_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic allocate_op(logic ld, xlen_t base, xlen_t offs, xlen_t data, logic err);
        int waited;
        xlen_t addr;
        waited = 0;
        addr = base + offs;
        alloc_en = 1'b1;
        is_load = ld;
        base_addr = base;
        offset = offs;
        store_data = data;
        phys_rd = next_tag;
        rob_idx = next_rob;
        #1;
        while (!alloc_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!alloc_ready) begin
            errors++;
            $display("[%s] allocation was never accepted", test_name);
        end else if (ld) begin
            exp_tag.push_back(next_tag);
            exp_val.push_back((addr[1:0] != 2'b00) ? '0 : word_value(addr));
            exp_exc.push_back((addr[1:0] != 2'b00) || err);
            next_tag++;
        end else begin
            pend_addr.push_back(addr);
            pend_data.push_back(data);
            pend_rob.push_back(next_rob);
            next_rob++;
        end
        @(negedge clk);
        alloc_en = 1'b0;
    endtask

    task automatic commit_oldest();
        xlen_t addr;
        xlen_t data;
        rob_idx_t rob;
        addr = pend_addr.pop_front();
        data = pend_data.pop_front();
        rob = pend_rob.pop_front();
        commit_en = 1'b1;
        commit_rob_idx = rob;
        if (addr[1:0] == 2'b00) begin
            model[addr] = data;
            exp_writes++;
        end else begin
            stx_expected++;
        end
        @(negedge clk);
        commit_en = 1'b0;
    endtask

    task automatic wait_loads_done();
        int waited;
        waited = 0;
        while (exp_tag.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_tag.size() != 0) begin
            errors++;
            $display("[%s] %0d load results never reached the CDB", test_name, exp_tag.size());
        end
    endtask

    // Committed stores all written or retired with an exception
    task automatic wait_writes_done();
        int waited;
        waited = 0;
        while ((got_writes != exp_writes || stx_seen != stx_expected) &&
               waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (got_writes != exp_writes || stx_seen != stx_expected) begin
            errors++;
            $display("[%s] committed stores did not drain", test_name);
        end
    endtask

    task automatic check_memory();
        xlen_t a;
        for (int k = 0; k < WORDS; k++) begin
            a = REGION + xlen_t'(4 * k);
            compare_value("scratchpad word", word_value(a), scratch_value(a));
        end
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        exp_tag.delete();
        exp_val.delete();
        exp_exc.delete();
        pend_addr.delete();
        pend_data.delete();
        pend_rob.delete();
        @(negedge clk);
        flush = 1'b0;
    endtask

    // ============================================================
    // Scratchpad responder and result monitor
    // ============================================================

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        mem_error = 1'b0;
        forever begin
            @(negedge clk);
            mem_ready = !mem_stall && ($urandom % 4 != 0);
            mem_rdata = '0;
            mem_error = 1'b0;
            if (!reset && mem_req) begin
                if (!mem_we && mem_addr == watch_addr) begin
                    watch_hits++;
                end
                // Transfer completes at the coming rising edge
                if (mem_ready && mem_we) begin
                    if (mem_addr[1:0] != 2'b00) begin
                        errors++;
                        $display("[%s] write to misaligned address %h", test_name, mem_addr);
                    end
                    scratch[mem_addr] = mem_wdata;
                    got_writes++;
                end else if (mem_ready) begin
                    mem_rdata = scratch_value(mem_addr);
                    mem_error = inject_error;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            if (exp_tag.size() == 0) begin
                errors++;
                $display("[%s] unexpected CDB result with tag %0d", test_name, cdb_tag);
            end else begin
                compare_value("cdb tag", 32'(exp_tag.pop_front()), 32'(cdb_tag));
                compare_value("cdb value", exp_val.pop_front(), cdb_value);
                compare_value("cdb exception", 32'(exp_exc.pop_front()), 32'(cdb_exception));
                loads_checked++;
            end
        end
        if (!reset && store_exception) begin
            stx_seen++;
        end
    end

    initial begin
        repeat (OP_BOUND * 200 + 2000) @(posedge clk);
        $display("Watchdog expired, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin
        int n;
        int saved;
        xlen_t w;
        xlen_t offs;
        flush = 1'b0;
        alloc_en = 1'b0;
        is_load = 1'b0;
        base_addr = '0;
        offset = '0;
        store_data = '0;
        phys_rd = '0;
        rob_idx = '0;
        commit_en = 1'b0;
        commit_rob_idx = '0;
        errors = 0;
        loads_checked = 0;
        exp_writes = 0;
        got_writes = 0;
        stx_seen = 0;
        stx_expected = 0;
        watch_hits = 0;
        watch_addr = '1;
        mem_stall = 1'b0;
        inject_error = 1'b0;
        next_tag = '0;
        next_rob = '0;
        void'($urandom(SEED));
        test_name = "reset";
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(negedge clk);
        compare_value("alloc_ready", 1, 32'(alloc_ready));
        compare_value("mem_req", 0, 32'(mem_req));
        compare_value("cdb_valid", 0, 32'(cdb_valid));
        compare_value("store_exception", 0, 32'(store_exception));

        test_name = "random stores then loads";
        for (int r = 0; r < ROUNDS; r++) begin
            n = 1 + $urandom % MAX_BATCH;
            for (int i = 0; i < n; i++) begin
                w = random_word();
                offs = xlen_t'(4 * ($urandom % 4));
                allocate_op(1'b0, w - offs, offs, $urandom, 1'b0);
            end
            for (int i = 0; i < n; i++) begin
                commit_oldest();
            end
            n = 1 + $urandom % MAX_BATCH;
            for (int i = 0; i < n; i++) begin
                allocate_op(1'b1, random_word(), '0, '0, 1'b0);
            end
            wait_loads_done();
        end
        wait_writes_done();
        check_memory();

        // Store stays in the queue, so the load must forward
        test_name = "forwarding under back-pressure";
        mem_stall = 1'b1;
        w = random_word();
        allocate_op(1'b0, w, '0, $urandom, 1'b0);
        commit_oldest();
        watch_addr = w;
        watch_hits = 0;
        allocate_op(1'b1, w, '0, '0, 1'b0);
        wait_loads_done();
        mem_stall = 1'b0;
        wait_writes_done();
        // A read of the word could only follow the drain
        wait_loads_done();
        compare_value("reads of forwarded word", 0, watch_hits);

        test_name = "misalignment";
        w = random_word();
        watch_addr = w + 1;
        watch_hits = 0;
        allocate_op(1'b1, w, 32'd1, '0, 1'b0);
        wait_loads_done();
        compare_value("misaligned load reads", 0, watch_hits);
        watch_addr = '1;
        saved = got_writes;
        allocate_op(1'b0, w, 32'd2, $urandom, 1'b0);
        commit_oldest();
        wait_writes_done();
        compare_value("writes after misaligned store", saved, got_writes);
        check_memory();

        test_name = "memory error";
        inject_error = 1'b1;
        allocate_op(1'b1, random_word(), '0, '0, 1'b1);
        wait_loads_done();
        inject_error = 1'b0;

        // Two committed and two uncommitted stores, loads stuck behind them
        test_name = "flush";
        mem_stall = 1'b1;
        for (int k = 0; k < 4; k++) begin
            allocate_op(1'b0, REGION + xlen_t'(4 * k), '0, $urandom, 1'b0);
        end
        commit_oldest();
        commit_oldest();
        allocate_op(1'b1, REGION + 32'h10, '0, '0, 1'b0);
        allocate_op(1'b1, REGION + 32'h14, '0, '0, 1'b0);
        repeat (4) @(negedge clk);
        apply_flush();
        mem_stall = 1'b0;
        wait_writes_done();
        repeat (20) @(negedge clk);
        check_memory();

        test_name = "full queue";
        for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
            allocate_op(1'b0, REGION + xlen_t'(4 * k), '0, $urandom, 1'b0);
        end
        is_load = 1'b0;
        #1;
        compare_value("store alloc_ready when full", 0, 32'(alloc_ready));
        is_load = 1'b1;
        #1;
        compare_value("load alloc_ready when full", 1, 32'(alloc_ready));
        // Word outside the stored region
        allocate_op(1'b1, REGION + xlen_t'(4 * WORDS), '0, '0, 1'b0);
        wait_loads_done();
        for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
            commit_oldest();
        end
        wait_writes_done();
        is_load = 1'b0;
        #1;
        compare_value("store alloc_ready after drain", 1, 32'(alloc_ready));
        check_memory();

        test_name = "end of run";
        repeat (10) @(negedge clk);
        compare_value("loads left in flight", 0, exp_tag.size());
        compare_value("store exceptions", stx_expected, stx_seen);
        errors += i_lsu_top.i_lsu_asserts.failures;
        $display("Summary: %0d errors (%0d from assertions), %0d loads checked, %0d writes",
                 errors, i_lsu_top.i_lsu_asserts.failures, loads_checked, got_writes);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_dispatch.sv
hw/lsu_load_queue.sv
hw/lsu_store_queue.sv
hw/lsu_mem_arbiter.sv
hw/lsu_top.sv
tests/lsu_clock_gen.sv
tests/lsu_asserts.sv
tests/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f sim.f &&
./obj_dir/Vlsu_tb | tee /dev/stderr | grep -x '\*\*\* PASSED \*\*\*' > /dev/null &&
echo "lsu simulation passed" ||
{ echo "lsu simulation failed"; exit 1; }
